// File: src/aluCore.sv
`timescale 1ns/1ns

module aluCore
    import executePkg::*;
(
    executeBus.alu bus,
    input aluOp_t aluControl
);

    word_t opA;
    word_t opB;
    word_t result;
    // shift amount from the low bits of srcB
    logic [4:0] shamt;
    logic lessSigned;
    logic lessUnsigned;

    assign opA = bus.srcA;
    assign opB = bus.srcB;
    assign shamt = opB[4:0];

    // compares shared by slt and sltu
    assign lessSigned = $signed(opA) < $signed(opB);
    assign lessUnsigned = opA < opB;

    always_comb begin
        case (aluControl)
            aluAdd: begin
                result = opA + opB;
            end
            aluSub: begin
                result = opA - opB;
            end
            aluAnd: begin
                result = opA & opB;
            end
            aluOr: begin
                result = opA | opB;
            end
            aluXor: begin
                result = opA ^ opB;
            end
            // compare answer lands in bit 0
            aluSlt: begin
                result = {{(xlen-1){1'b0}}, lessSigned};
            end
            aluSltu: begin
                result = {{(xlen-1){1'b0}}, lessUnsigned};
            end
            aluSll: begin
                result = opA << shamt;
            end
            aluSrl: begin
                result = opA >> shamt;
            end
            // arithmetic shift keeps the sign
            aluSra: begin
                result = word_t'($signed(opA) >>> shamt);
            end
            // unused codes
            default: begin
                result = '0;
            end
        endcase
    end

    assign bus.aluResult = result;
    // zero flag drives beq and bne
    assign bus.zero = (result == '0);

endmodule

// File: src/branchResolve.sv
`timescale 1ns/1ns

module branchResolve
    import executePkg::*;
(
    executeBus.resolve bus,
    input logic branch,
    input logic jump,
    input logic jumpReg,
    input logic [2:0] funct3,
    input word_t pc,
    input word_t imm,
    output logic pcSrc,
    output word_t pcTarget
);

    logic condMet;
    logic branchTaken;
    // bit 0 of the alu result holds the slt or sltu answer
    logic lessFlag;
    word_t pcRelTarget;
    word_t regRelTarget;

    assign lessFlag = bus.aluResult[0];

    // condition decode from funct3
    always_comb begin
        case (funct3)
            brEq: begin
                condMet = bus.zero;
            end
            brNe: begin
                condMet = !bus.zero;
            end
            brLt, brLtu: begin
                condMet = lessFlag;
            end
            brGe, brGeu: begin
                condMet = !lessFlag;
            end
            // 2 and 3 are not branch codes
            default: begin
                condMet = 1'b0;
            end
        endcase
    end

    assign branchTaken = branch && condMet;

    // redirect on any taken control transfer
    assign pcSrc = branchTaken || jump || jumpReg;

    // jal and branches are pc relative
    assign pcRelTarget = pc + imm;
    // jalr uses forwarded rs1, low bit dropped
    assign regRelTarget = (bus.srcA + imm) & jalrMask;

    assign pcTarget = jumpReg ? regRelTarget : pcRelTarget;

endmodule

// File: src/exMemReg.sv
`timescale 1ns/1ns

module exMemReg
    import executePkg::*;
(
    input logic clk,
    input logic rst,
    input exMemCtrl_t ctrlE,
    input word_t pcPlus4E,
    executeBus.capture bus,
    output exMemCtrl_t ctrlM,
    output word_t pcPlus4M,
    output word_t aluResultM,
    output word_t writeDataM
);

    exMemCtrl_t ctrlQ;
    word_t pcPlus4Q;
    word_t aluResultQ;
    word_t writeDataQ;

    // stage advances every cycle, no stall input
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // controls inactive, writeReg and data cleared
            ctrlQ <= '0;
            pcPlus4Q <= '0;
            aluResultQ <= '0;
            writeDataQ <= '0;
        end else begin
            ctrlQ <= ctrlE;
            // return address for jal and jalr writeback
            pcPlus4Q <= pcPlus4E;
            aluResultQ <= bus.aluResult;
            // forwarded rs2 for stores
            writeDataQ <= bus.storeData;
        end
    end

    assign ctrlM = ctrlQ;
    assign pcPlus4M = pcPlus4Q;
    assign aluResultM = aluResultQ;
    assign writeDataM = writeDataQ;

endmodule

// File: src/executeBus.sv
`timescale 1ns/1ns

// operand and alu signals shared inside the execute stage
interface executeBus
    import executePkg::*;
();

    // first alu operand after forwarding
    word_t srcA;
    // second alu operand after the immediate select
    word_t srcB;
    // forwarded rs2 value, goes to memory as store data
    word_t storeData;
    // alu outputs
    word_t aluResult;
    logic zero;

    // forwarding and immediate select
    modport operand (
        output srcA, srcB, storeData
    );

    // alu
    modport alu (
        input srcA, srcB,
        output aluResult, zero
    );

    // branch decision and target
    modport resolve (
        input srcA, aluResult, zero
    );

    // ex/mem register
    modport capture (
        input aluResult, storeData
    );

endinterface

// File: src/executePkg.sv
package executePkg;

    // datapath and address width
    localparam int xlen = 32;
    // register number width
    localparam int regAddrW = 5;

    typedef logic [xlen-1:0] word_t;
    typedef logic [regAddrW-1:0] regAddr_t;

    // alu operation encoding
    // codes 10 to 15 are unused and give a zero result
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluSlt  = 4'd5,
        aluSltu = 4'd6,
        aluSll  = 4'd7,
        aluSrl  = 4'd8,
        aluSra  = 4'd9
    } aluOp_t;

    // forwarding source for an operand
    // code 3 falls back to the register file value
    typedef enum logic [1:0] {
        fwdReg = 2'd0,
        fwdWb  = 2'd1,
        fwdMem = 2'd2
    } fwdSel_t;

    // branch funct3 codes
    localparam logic [2:0] brEq  = 3'b000;
    localparam logic [2:0] brNe  = 3'b001;
    localparam logic [2:0] brLt  = 3'b100;
    localparam logic [2:0] brGe  = 3'b101;
    localparam logic [2:0] brLtu = 3'b110;
    localparam logic [2:0] brGeu = 3'b111;

    // clears bit 0 of a jalr target
    localparam word_t jalrMask = 32'hFFFF_FFFE;

    // controls carried across the ex/mem boundary
    typedef struct packed {
        // result goes back to the register file
        logic regWrite;
        // writeback takes the load data
        logic memToReg;
        // store to data memory
        logic memWrite;
        // jal or jalr, writeback uses pc+4
        logic jump;
        // destination register
        regAddr_t writeReg;
    } exMemCtrl_t;

endpackage

// File: src/executeStage.sv
`timescale 1ns/1ns

module executeStage
    import executePkg::*;
(
    input logic clk,
    input logic rst,
    input logic regWriteE,
    input logic memToRegE,
    input logic memWriteE,
    input logic aluSrcE,
    input logic branchE,
    input logic jumpE,
    input logic jumpRegE,
    input logic [2:0] funct3E,
    input aluOp_t aluControlE,
    input word_t rd1E,
    input word_t rd2E,
    input word_t immE,
    input word_t pcE,
    input word_t pcPlus4E,
    input word_t resultW,
    input word_t memValue,
    input regAddr_t writeRegE,
    input fwdSel_t forwardAE,
    input fwdSel_t forwardBE,
    output logic pcSrc,
    output word_t pcTarget,
    output logic regWriteM,
    output logic memToRegM,
    output logic memWriteM,
    output logic jumpM,
    output regAddr_t writeRegM,
    output word_t pcPlus4M,
    output word_t aluResultM,
    output word_t writeDataM
);

    exMemCtrl_t ctrlE;
    exMemCtrl_t ctrlM;

    // operands and alu outputs between submodules
    executeBus bus ();

    // control bits bundled for the pipeline register
    assign ctrlE.regWrite = regWriteE;
    assign ctrlE.memToReg = memToRegE;
    assign ctrlE.memWrite = memWriteE;
    assign ctrlE.jump = jumpE;
    assign ctrlE.writeReg = writeRegE;

    operandSelect uOperandSelect (
        .rd1(rd1E),
        .rd2(rd2E),
        .imm(immE),
        .resultW(resultW),
        .memValue(memValue),
        .forwardA(forwardAE),
        .forwardB(forwardBE),
        .aluSrc(aluSrcE),
        .branch(branchE),
        .bus(bus.operand)
    );

    aluCore uAluCore (
        .bus(bus.alu),
        .aluControl(aluControlE)
    );

    // redirect is resolved in this cycle, fetch and decode flush on pcSrc
    branchResolve uBranchResolve (
        .bus(bus.resolve),
        .branch(branchE),
        .jump(jumpE),
        .jumpReg(jumpRegE),
        .funct3(funct3E),
        .pc(pcE),
        .imm(immE),
        .pcSrc(pcSrc),
        .pcTarget(pcTarget)
    );

    exMemReg uExMemReg (
        .clk(clk),
        .rst(rst),
        .ctrlE(ctrlE),
        .pcPlus4E(pcPlus4E),
        .bus(bus.capture),
        .ctrlM(ctrlM),
        .pcPlus4M(pcPlus4M),
        .aluResultM(aluResultM),
        .writeDataM(writeDataM)
    );

    // registered controls back onto plain ports
    assign regWriteM = ctrlM.regWrite;
    assign memToRegM = ctrlM.memToReg;
    assign memWriteM = ctrlM.memWrite;
    assign jumpM = ctrlM.jump;
    assign writeRegM = ctrlM.writeReg;

endmodule

// File: src/operandSelect.sv
`timescale 1ns/1ns

module operandSelect
    import executePkg::*;
(
    input word_t rd1,
    input word_t rd2,
    input word_t imm,
    input word_t resultW,
    input word_t memValue,
    input fwdSel_t forwardA,
    input fwdSel_t forwardB,
    input logic aluSrc,
    input logic branch,
    executeBus.operand bus
);

    word_t fwdA;
    word_t fwdB;

    // three-way forwarding mux
    // select 3 is treated like the register file value
    function automatic word_t pickSource(
        input fwdSel_t sel,
        input word_t regValue,
        input word_t wbValue,
        input word_t memStageValue
    );
        word_t picked;
        case (sel)
            fwdWb: picked = wbValue;
            fwdMem: picked = memStageValue;
            default: picked = regValue;
        endcase
        return picked;
    endfunction

    // rs1 side
    assign fwdA = pickSource(forwardA, rd1, resultW, memValue);
    // rs2 side, also the store data
    assign fwdB = pickSource(forwardB, rd2, resultW, memValue);

    assign bus.srcA = fwdA;

    // immediate only for non-branch instructions
    // branches always compare rs1 against rs2
    assign bus.srcB = (aluSrc && !branch) ? imm : fwdB;

    // stores write the forwarded rs2, never the immediate
    assign bus.storeData = fwdB;

endmodule

// File: include/executeTbModel.svh
`ifndef EXECUTE_TB_MODEL_SVH
`define EXECUTE_TB_MODEL_SVH

// reference models for the execute stage checks
// included inside a module that imports executePkg::*

// forwarding mux model, code 3 gives the register value
function automatic word_t fwdModel(
    input fwdSel_t sel,
    input word_t regValue,
    input word_t wbValue,
    input word_t memStageValue
);
    if (sel == fwdWb) begin
        return wbValue;
    end
    if (sel == fwdMem) begin
        return memStageValue;
    end
    return regValue;
endfunction

// expected alu result
function automatic word_t aluModel(input aluOp_t op, input word_t a, input word_t b);
    word_t r;
    case (op)
        aluAdd: r = a + b;
        aluSub: r = a - b;
        aluAnd: r = a & b;
        aluOr: r = a | b;
        aluXor: r = a ^ b;
        aluSlt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        aluSltu: r = (a < b) ? 32'd1 : 32'd0;
        aluSll: r = a << b[4:0];
        aluSrl: r = a >> b[4:0];
        aluSra: r = word_t'($signed(a) >>> b[4:0]);
        default: r = '0;
    endcase
    return r;
endfunction

// expected pcSrc from the alu result of the same vector
function automatic logic pcSrcModel(
    input logic branch,
    input logic jump,
    input logic jumpReg,
    input logic [2:0] funct3,
    input word_t aluResult
);
    logic taken;
    case (funct3)
        brEq: taken = (aluResult == '0);
        brNe: taken = (aluResult != '0);
        brLt, brLtu: taken = aluResult[0];
        brGe, brGeu: taken = !aluResult[0];
        default: taken = 1'b0;
    endcase
    return (branch && taken) || jump || jumpReg;
endfunction

// expected redirect target
function automatic word_t targetModel(
    input logic jumpReg,
    input word_t srcA,
    input word_t pc,
    input word_t imm
);
    if (jumpReg) begin
        return (srcA + imm) & jalrMask;
    end
    return pc + imm;
endfunction

`endif

// File: tests/executeStageTb.sv
`timescale 1ns/1ns

module executeStageTb
    import executePkg::*;
();

    `include "executeTbModel.svh"

    localparam int resetCycles = 5;
    localparam int numDirected = 23;
    localparam int numRandom = 200;
    // twice the expected run length plus slack
    localparam int cycleLimit = 2 * (resetCycles + numDirected + numRandom) + 20;

    // one instruction and its expected results
    // ctrl is {regWrite, memToReg, memWrite, aluSrc, branch, jump, jumpReg}
    typedef struct packed {
        logic [6:0] ctrl;
        logic [2:0] funct3;
        logic [3:0] op;
        logic [1:0] fwdA;
        logic [1:0] fwdB;
        word_t rd1;
        word_t rd2;
        word_t imm;
        word_t pc;
        word_t resultW;
        word_t memValue;
        logic expPcSrc;
        word_t expTarget;
        word_t expAlu;
        word_t expWriteData;
    } vector_t;

    logic clk;
    logic rst;
    logic regWriteE;
    logic memToRegE;
    logic memWriteE;
    logic aluSrcE;
    logic branchE;
    logic jumpE;
    logic jumpRegE;
    logic [2:0] funct3E;
    aluOp_t aluControlE;
    word_t rd1E;
    word_t rd2E;
    word_t immE;
    word_t pcE;
    word_t pcPlus4E;
    word_t resultW;
    word_t memValue;
    regAddr_t writeRegE;
    fwdSel_t forwardAE;
    fwdSel_t forwardBE;
    logic pcSrc;
    word_t pcTarget;
    logic regWriteM;
    logic memToRegM;
    logic memWriteM;
    logic jumpM;
    regAddr_t writeRegM;
    word_t pcPlus4M;
    word_t aluResultM;
    word_t writeDataM;

    vector_t vectors [0:numDirected-1];
    int rowCount = 0;
    int passCount = 0;
    int failCount = 0;
    int cycleCount = 0;
    integer seed;

    // what the EX/MEM register should hold after the previous vector
    vector_t prevVec;
    regAddr_t prevWriteReg;
    word_t prevPcPlus4;

    executeStage dut (
        .clk(clk),
        .rst(rst),
        .regWriteE(regWriteE),
        .memToRegE(memToRegE),
        .memWriteE(memWriteE),
        .aluSrcE(aluSrcE),
        .branchE(branchE),
        .jumpE(jumpE),
        .jumpRegE(jumpRegE),
        .funct3E(funct3E),
        .aluControlE(aluControlE),
        .rd1E(rd1E),
        .rd2E(rd2E),
        .immE(immE),
        .pcE(pcE),
        .pcPlus4E(pcPlus4E),
        .resultW(resultW),
        .memValue(memValue),
        .writeRegE(writeRegE),
        .forwardAE(forwardAE),
        .forwardBE(forwardBE),
        .pcSrc(pcSrc),
        .pcTarget(pcTarget),
        .regWriteM(regWriteM),
        .memToRegM(memToRegM),
        .memWriteM(memWriteM),
        .jumpM(jumpM),
        .writeRegM(writeRegM),
        .pcPlus4M(pcPlus4M),
        .aluResultM(aluResultM),
        .writeDataM(writeDataM)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            failCount++;
            $display("Error %s got 0x%h expected 0x%h", name, got, expected);
        end else begin
            passCount++;
        end
    endtask

    // M outputs against the vector applied one cycle earlier
    task automatic checkRegistered();
        checkValue("regWriteM", regWriteM, prevVec.ctrl[6]);
        checkValue("memToRegM", memToRegM, prevVec.ctrl[5]);
        checkValue("memWriteM", memWriteM, prevVec.ctrl[4]);
        checkValue("jumpM", jumpM, prevVec.ctrl[1]);
        checkValue("writeRegM", writeRegM, prevWriteReg);
        checkValue("pcPlus4M", pcPlus4M, prevPcPlus4);
        checkValue("aluResultM", aluResultM, prevVec.expAlu);
        checkValue("writeDataM", writeDataM, prevVec.expWriteData);
    endtask

    // all inputs zero so the alu adds zeros with no controls set
    task automatic driveIdle();
        {regWriteE, memToRegE, memWriteE, aluSrcE} <= 4'b0;
        {branchE, jumpE, jumpRegE} <= 3'b0;
        funct3E <= 3'd0;
        aluControlE <= aluAdd;
        forwardAE <= fwdReg;
        forwardBE <= fwdReg;
        {rd1E, rd2E, immE, pcE} <= '0;
        {pcPlus4E, resultW, memValue} <= '0;
        writeRegE <= '0;
    endtask

    // drive on the rising edge and check on the falling edge
    task automatic applyVector(input vector_t v, input regAddr_t writeReg);
        @(posedge clk);
        {regWriteE, memToRegE, memWriteE, aluSrcE} <= v.ctrl[6:3];
        {branchE, jumpE, jumpRegE} <= v.ctrl[2:0];
        funct3E <= v.funct3;
        aluControlE <= aluOp_t'(v.op);
        forwardAE <= fwdSel_t'(v.fwdA);
        forwardBE <= fwdSel_t'(v.fwdB);
        rd1E <= v.rd1;
        rd2E <= v.rd2;
        immE <= v.imm;
        pcE <= v.pc;
        pcPlus4E <= v.pc + 32'd4;
        resultW <= v.resultW;
        memValue <= v.memValue;
        writeRegE <= writeReg;
        @(negedge clk);
        // redirect is combinational in this cycle
        checkValue("pcSrc", pcSrc, v.expPcSrc);
        checkValue("pcTarget", pcTarget, v.expTarget);
        // previous instruction now in the EX/MEM register
        checkRegistered();
        prevVec = v;
        prevWriteReg = writeReg;
        prevPcPlus4 = v.pc + 32'd4;
    endtask

    // one idle cycle to check the last vector of a sequence
    task automatic drainStage();
        @(posedge clk);
        driveIdle();
        @(negedge clk);
        checkRegistered();
        prevVec = '0;
        prevWriteReg = '0;
        prevPcPlus4 = '0;
    endtask

    task automatic addRow(input logic [6:0] ctrl, input logic [2:0] f3, input logic [3:0] op,
                          input logic [1:0] fa, input logic [1:0] fb,
                          input word_t rd1, input word_t rd2, input word_t imm, input word_t pc,
                          input word_t resW, input word_t memV, input logic expSrc,
                          input word_t expTgt, input word_t expAlu, input word_t expWd);
        vector_t row;
        row = '0;
        row.ctrl = ctrl;
        row.funct3 = f3;
        row.op = op;
        row.fwdA = fa;
        row.fwdB = fb;
        row.rd1 = rd1;
        row.rd2 = rd2;
        row.imm = imm;
        row.pc = pc;
        row.resultW = resW;
        row.memValue = memV;
        row.expPcSrc = expSrc;
        row.expTarget = expTgt;
        row.expAlu = expAlu;
        row.expWriteData = expWd;
        vectors[rowCount] = row;
        rowCount++;
    endtask

    // directed vectors with hand-computed expected values
    task automatic fillTable();
        // add of register file operands
        addRow(7'b1000000, 3'd0, 4'd0, 2'd0, 2'd0, 32'h10, 32'h20, 32'h4, 32'h100,
            32'h1000, 32'h2000, 1'b0, 32'h104, 32'h30, 32'h20);
        // sub with A from writeback and B from memory
        addRow(7'b1000000, 3'd0, 4'd1, 2'd1, 2'd2, 32'h10, 32'h20, 32'h8, 32'h200,
            32'h500, 32'h100, 1'b0, 32'h208, 32'h400, 32'h100);
        // and with A from memory and B from writeback
        addRow(7'b1000000, 3'd0, 4'd2, 2'd2, 2'd1, 32'h1, 32'h2, 32'h0, 32'h300,
            32'hFF00_FF00, 32'hF0F0_F0F0, 1'b0, 32'h300, 32'hF000_F000, 32'hFF00_FF00);
        // or where select 3 on both sides acts like the register file
        addRow(7'b1000000, 3'd0, 4'd3, 2'd3, 2'd3, 32'h0F00_0000, 32'hF0, 32'h10, 32'h400,
            32'hDEAD, 32'hBEEF, 1'b0, 32'h410, 32'h0F00_00F0, 32'hF0);
        addRow(7'b1000000, 3'd0, 4'd4, 2'd0, 2'd0, 32'hAAAA_5555, 32'hFFFF_0000, 32'h0,
            32'h500, 32'h0, 32'h0, 1'b0, 32'h500, 32'h5555_5555, 32'hFFFF_0000);
        // slt and sltu on -1 against 1
        addRow(7'b1000000, 3'd0, 4'd5, 2'd0, 2'd0, 32'hFFFF_FFFF, 32'h1, 32'h4, 32'h600,
            32'h0, 32'h0, 1'b0, 32'h604, 32'h1, 32'h1);
        addRow(7'b1000000, 3'd0, 4'd6, 2'd0, 2'd0, 32'hFFFF_FFFF, 32'h1, 32'h4, 32'h700,
            32'h0, 32'h0, 1'b0, 32'h704, 32'h0, 32'h1);
        // sll by immediate where only the low five bits count
        addRow(7'b1001000, 3'd0, 4'd7, 2'd0, 2'd0, 32'h1, 32'h5, 32'h24, 32'h800,
            32'h0, 32'h0, 1'b0, 32'h824, 32'h10, 32'h5);
        addRow(7'b1000000, 3'd0, 4'd8, 2'd0, 2'd0, 32'h8000_0000, 32'h21, 32'h0, 32'h900,
            32'h0, 32'h0, 1'b0, 32'h900, 32'h4000_0000, 32'h21);
        // sra keeps the sign
        addRow(7'b1001000, 3'd0, 4'd9, 2'd0, 2'd0, 32'h8000_0000, 32'h7, 32'h4, 32'hA00,
            32'h0, 32'h0, 1'b0, 32'hA04, 32'hF800_0000, 32'h7);
        // store with the address from the immediate and data forwarded from writeback
        addRow(7'b0011000, 3'd0, 4'd0, 2'd0, 2'd1, 32'h1000, 32'h3, 32'h8, 32'hB00,
            32'hCAFE, 32'h0, 1'b0, 32'hB08, 32'h1008, 32'hCAFE);
        // beq with aluSrc set still compares registers
        addRow(7'b0001100, 3'd0, 4'd1, 2'd0, 2'd0, 32'h55, 32'h55, 32'h40, 32'hC00,
            32'h0, 32'h0, 1'b1, 32'hC40, 32'h0, 32'h55);
        addRow(7'b0000100, 3'd1, 4'd1, 2'd0, 2'd0, 32'h55, 32'h55, 32'h10, 32'hD00,
            32'h0, 32'h0, 1'b0, 32'hD10, 32'h0, 32'h55);
        // taken bne with a backward target
        addRow(7'b0000100, 3'd1, 4'd1, 2'd0, 2'd0, 32'h56, 32'h55, 32'hFFFF_FFF0, 32'hE00,
            32'h0, 32'h0, 1'b1, 32'hDF0, 32'h1, 32'h55);
        // blt, bge, bltu, bgeu on -2 against 3
        addRow(7'b0000100, 3'd4, 4'd5, 2'd0, 2'd0, 32'hFFFF_FFFE, 32'h3, 32'h20, 32'hF00,
            32'h0, 32'h0, 1'b1, 32'hF20, 32'h1, 32'h3);
        addRow(7'b0000100, 3'd5, 4'd5, 2'd0, 2'd0, 32'hFFFF_FFFE, 32'h3, 32'h20, 32'h1000,
            32'h0, 32'h0, 1'b0, 32'h1020, 32'h1, 32'h3);
        addRow(7'b0000100, 3'd6, 4'd6, 2'd0, 2'd0, 32'hFFFF_FFFE, 32'h3, 32'h8, 32'h1100,
            32'h0, 32'h0, 1'b0, 32'h1108, 32'h0, 32'h3);
        addRow(7'b0000100, 3'd7, 4'd6, 2'd0, 2'd0, 32'hFFFF_FFFE, 32'h3, 32'h8, 32'h1200,
            32'h0, 32'h0, 1'b1, 32'h1208, 32'h0, 32'h3);
        // funct3 2 is never taken
        addRow(7'b0000100, 3'd2, 4'd1, 2'd0, 2'd0, 32'h5, 32'h5, 32'h4, 32'h1300,
            32'h0, 32'h0, 1'b0, 32'h1304, 32'h0, 32'h5);
        // jal
        addRow(7'b1000010, 3'd0, 4'd0, 2'd0, 2'd0, 32'h0, 32'h0, 32'h100, 32'h1400,
            32'h0, 32'h0, 1'b1, 32'h1500, 32'h0, 32'h0);
        // jalr with the base forwarded from memory then from writeback
        addRow(7'b1001001, 3'd0, 4'd0, 2'd2, 2'd0, 32'h9999, 32'h4, 32'h10, 32'h1500,
            32'h0, 32'h2001, 1'b1, 32'h2010, 32'h2011, 32'h4);
        addRow(7'b1101001, 3'd0, 4'd0, 2'd1, 2'd2, 32'h9999, 32'h4, 32'h7, 32'h1600,
            32'h3000, 32'h77, 1'b1, 32'h3006, 32'h3007, 32'h77);
        // unused alu code
        addRow(7'b1000000, 3'd0, 4'd10, 2'd0, 2'd0, 32'h1234, 32'h5678, 32'h0, 32'h1700,
            32'h0, 32'h0, 1'b0, 32'h1700, 32'h0, 32'h5678);
    endtask

    // random instruction checked against the reference functions
    task automatic makeRandomVector(output vector_t v);
        word_t srcA;
        word_t fwdB;
        word_t srcB;
        v = '0;
        v.ctrl = $random(seed);
        v.funct3 = $random(seed);
        v.op = $random(seed);
        v.fwdA = $random(seed);
        v.fwdB = $random(seed);
        v.rd1 = $random(seed);
        v.rd2 = $random(seed);
        v.imm = $random(seed);
        v.pc = $random(seed);
        v.resultW = $random(seed);
        v.memValue = $random(seed);
        // equal operands now and then so beq and bne both resolve
        if (($random(seed) & 3) == 0) begin
            v.rd2 = v.rd1;
            v.memValue = v.resultW;
        end
        srcA = fwdModel(fwdSel_t'(v.fwdA), v.rd1, v.resultW, v.memValue);
        fwdB = fwdModel(fwdSel_t'(v.fwdB), v.rd2, v.resultW, v.memValue);
        // immediate only when aluSrc is set and branch is clear
        srcB = (v.ctrl[3] && !v.ctrl[2]) ? v.imm : fwdB;
        v.expAlu = aluModel(aluOp_t'(v.op), srcA, srcB);
        v.expPcSrc = pcSrcModel(v.ctrl[2], v.ctrl[1], v.ctrl[0], v.funct3, v.expAlu);
        v.expTarget = targetModel(v.ctrl[0], srcA, v.pc, v.imm);
        v.expWriteData = fwdB;
    endtask

    task automatic reportTest(input string name, input int failsBefore);
        if (failCount == failsBefore) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s had %0d errors", name, failCount - failsBefore);
        end
    endtask

    initial begin
        int failsBefore;
        vector_t v;
        regAddr_t wreg;
        seed = 32'h8c4f_8425;
        prevVec = '0;
        prevWriteReg = '0;
        prevPcPlus4 = '0;
        fillTable();
        // register must read zero despite busy inputs during reset
        rst = 1'b1;
        {regWriteE, memToRegE, memWriteE, aluSrcE} = 4'b1111;
        {branchE, jumpE, jumpRegE} = 3'b0;
        funct3E = 3'd0;
        aluControlE = aluOr;
        forwardAE = fwdWb;
        forwardBE = fwdMem;
        rd1E = 32'h1357_9BDF;
        rd2E = 32'h2468_ACE0;
        immE = 32'h40;
        pcE = 32'h80;
        pcPlus4E = 32'h84;
        resultW = 32'h0F0F_0F0F;
        memValue = 32'hF0F0_F0F0;
        writeRegE = 5'h1F;

        failsBefore = failCount;
        repeat (resetCycles - 1) begin
            @(posedge clk);
            @(negedge clk);
            checkRegistered();
        end
        // release on the fifth reset edge with idle inputs
        @(posedge clk);
        rst <= 1'b0;
        driveIdle();
        @(negedge clk);
        checkRegistered();
        reportTest("reset", failsBefore);

        failsBefore = failCount;
        for (int i = 0; i < rowCount; i++) begin
            applyVector(vectors[i], regAddr_t'(i + 1));
        end
        drainStage();
        reportTest("directed", failsBefore);

        failsBefore = failCount;
        for (int i = 0; i < numRandom; i++) begin
            makeRandomVector(v);
            wreg = $random(seed);
            applyVector(v, wreg);
        end
        drainStage();
        reportTest("random", failsBefore);

        $display("checks passed %0d failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
src/executePkg.sv
src/executeBus.sv
src/operandSelect.sv
src/aluCore.sv
src/branchResolve.sv
src/exMemReg.sv
src/executeStage.sv
tests/executeStageTb.sv
